// File: project.f
+incdir+.
vec_pkg.sv
vec_credit_fifo.sv
vec_decode.sv
vec_regfile.sv
vec_alu.sv
vec_exec_pipe.sv
vec_unit_top.sv
tb_vec_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the vector unit testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_vec_unit \
    -Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi

echo "Simulation PASSED"

// File: tb_vec_unit.sv
`include "vec_cfg.svh"

module tb_vec_unit
    import vec_pkg::*;
();

    typedef logic [`VEC_ELEM_W-1:0] elem_t;

    localparam int N_RANDOM = 400;
    localparam int MAX_CYCLES = N_RANDOM * 40 + 2000;
    localparam logic [31:0] SEED = 32'h6fa14846;

    logic        CLK = 1'b0;
    logic        reset;
    logic        instr_valid;
    vec_instr_t  instr;
    logic        instr_credit;
    logic        result_valid;
    vec_result_t result;
    logic        result_credit;

    vec_data_t   ref_regs [`VEC_REGS];
    vec_result_t exp_q [$];
    logic [31:0] rng_state;
    int          iss_credits;
    int          owed;    // Results taken but not yet credited back.
    int          stall;
    int          sent_cnt = 0;
    int          icredit_cnt = 0;
    int          results_seen = 0;
    int          granted = 0;
    logic        sent_any = 1'b0;
    int          value_errors = 0;
    int          proto_errors = 0;
    int          cycle_count = 0;

    vec_unit_top uut (
        .CLK           (CLK),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_credit  (instr_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    always #10 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic vec_data_t random_vec();
        vec_data_t v;
        for (int i = 0; i < `VEC_LANES; i++) begin
            v[i] = elem_t'(next_rand());
        end
        return v;
    endfunction

    // One lane of the reference; fn is the funct7 code of the arithmetic op.
    function automatic elem_t lane_ref(input int fn, input elem_t a, input elem_t b);
        logic [2*`VEC_ELEM_W-1:0] prod;
        int unsigned amt;
        amt  = b % `VEC_ELEM_W;
        prod = a * b;
        case (fn)
            0: return a + b;
            1: return a - b;
            2: return a >> amt;
            3: return a << amt;
            4: return a & b;
            5: return a | b;
            6: return a ^ b;
            default: return prod[`VEC_ELEM_W-1:0];    // MUL keeps the low half.
        endcase
    endfunction

    function automatic vec_result_t expect_result(input vec_instr_t ins);
        vec_result_t r;
        r.vd      = ins.vd;
        r.illegal = 1'b0;
        r.data    = '0;
        if (ins.opcode == OP_VLOAD) begin
            r.data = ins.data;
        end else if (ins.opcode == OP_VARITH && ins.funct3 == OPIVV && ins.funct7 < 7'd8) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                r.data[i] = lane_ref(int'(ins.funct7), ref_regs[ins.vs1][i],
                                     ref_regs[ins.vs2][i]);
            end
        end else begin
            r.illegal = 1'b1;
        end
        if (!r.illegal) begin
            ref_regs[ins.vd] = r.data;
        end
        return r;
    endfunction

    function automatic vec_instr_t random_instr(input vreg_idx_t last_vd,
                                                input vreg_idx_t prev_vd);
        vec_instr_t ins;
        int kind;
        int dep;
        ins.data   = random_vec();
        ins.vd     = vreg_idx_t'(next_rand());
        ins.vs1    = vreg_idx_t'(next_rand());
        ins.vs2    = vreg_idx_t'(next_rand());
        ins.opcode = OP_VARITH;
        ins.funct3 = OPIVV;
        ins.funct7 = 7'(next_rand() % 8);
        kind = int'(next_rand() % 32);
        if (kind < 4) begin
            ins.opcode = OP_VLOAD;
            ins.funct3 = 3'(next_rand());
            ins.funct7 = 7'(next_rand());
        end else if (kind == 4) begin
            ins.opcode = 7'b0110011;    // Scalar OP, not a vector opcode.
        end else if (kind == 5) begin
            ins.funct3 = 3'(next_rand() % 7 + 1);
        end else if (kind == 6) begin
            ins.funct7 = 7'(next_rand() % 120 + 8);
        end
        // Chain onto recent destinations so both hazard distances come up often.
        dep = int'(next_rand() % 4);
        case (dep)
            0: ins.vs1 = last_vd;
            1: ins.vs2 = last_vd;
            2: ins.vs1 = prev_vd;
            default: ;
        endcase
        return ins;
    endfunction

    task automatic check_result(input vec_result_t got);
        vec_result_t exp;
        int bad;
        if (exp_q.size() == 0) begin
            value_errors++;
            $display("At %0t a result arrived with no instruction left to match it.", $time);
            return;
        end
        exp = exp_q.pop_front();
        bad = -1;
        for (int i = `VEC_LANES - 1; i >= 0; i--) begin
            if (got.data[i] != exp.data[i]) begin
                bad = i;
            end
        end
        assert (got.vd == exp.vd) else begin
            value_errors++;
            $display("FAILED at %0t: result.vd = %0d, expected %0d", $time, got.vd, exp.vd);
        end
        assert (got.illegal == exp.illegal) else begin
            value_errors++;
            $display("FAILED at %0t: result.illegal = %0b, expected %0b",
                     $time, got.illegal, exp.illegal);
        end
        assert (bad < 0) else begin
            value_errors++;
            $display("FAILED at %0t: result.data[%0d] = %h, expected %h",
                     $time, bad, got.data[bad], exp.data[bad]);
        end
    endtask

    task automatic observe_outputs(output logic credit_back);
        credit_back = instr_credit;
        if (instr_credit) begin
            icredit_cnt++;
        end
        if (result_valid) begin
            results_seen++;
            owed++;
            check_result(result);
        end
    endtask

    task automatic drive_consumer();
        result_credit = 1'b0;
        if (stall > 0) begin
            stall--;
        end else if (next_rand() % 48 == 0) begin
            stall = 10 + int'(next_rand() % 30);    // A stretch with no credits at all.
        end else if (owed > 0 && next_rand() % 4 != 0) begin
            result_credit = 1'b1;
            owed--;
            granted++;
        end
    endtask

    task automatic cycle(input logic have, input vec_instr_t ins, output logic taken);
        logic credit_back;
        @(negedge CLK);
        observe_outputs(credit_back);
        drive_consumer();
        taken = have && iss_credits > 0;
        instr_valid = taken;
        if (taken) begin
            instr = ins;
            iss_credits--;
            sent_cnt++;
            sent_any = 1'b1;
        end
        // A credit seen this cycle is spent no earlier than the next one.
        if (credit_back) begin
            iss_credits++;
        end
    endtask

    task automatic issue(input vec_instr_t ins);
        logic taken;
        exp_q.push_back(expect_result(ins));
        taken = 1'b0;
        while (!taken) begin
            cycle(1'b1, ins, taken);
        end
    endtask

    a_quiet_after_reset: assert property (
        @(posedge CLK) disable iff (reset)
        !sent_any |-> !instr_credit && !result_valid
    ) else begin
        proto_errors++;
        $display("At %0t the DUT pulsed a credit or result before any instruction.", $time);
    end

    a_issue_window: assert property (
        @(posedge CLK) disable iff (reset)
        icredit_cnt <= sent_cnt
    ) else begin
        proto_errors++;
        $display("At %0t the DUT returned more issue credits than instructions sent.", $time);
    end

    a_out_credit: assert property (
        @(posedge CLK) disable iff (reset)
        results_seen <= granted + `VEC_OUT_CREDITS
    ) else begin
        proto_errors++;
        $display("At %0t the DUT sent a result without a consumer credit.", $time);
    end

    a_no_extra_result: assert property (
        @(posedge CLK) disable iff (reset)
        results_seen <= sent_cnt
    ) else begin
        proto_errors++;
        $display("At %0t the DUT returned more results than instructions.", $time);
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results received.",
                     MAX_CYCLES, results_seen, sent_cnt);
            $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        vec_instr_t ins;
        vreg_idx_t  last_vd;
        vreg_idx_t  prev_vd;
        logic       taken;
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        result_credit = 1'b0;
        rng_state     = SEED;
        iss_credits   = `VEC_IQ_DEPTH;
        owed          = 0;
        stall         = 0;
        ins           = '0;
        for (int r = 0; r < `VEC_REGS; r++) begin
            ref_regs[r] = '0;
        end

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        repeat (5) cycle(1'b0, ins, taken);

        for (int r = 0; r < `VEC_REGS; r++) begin
            ins        = '0;
            ins.opcode = OP_VLOAD;
            ins.vd     = vreg_idx_t'(r);
            ins.data   = random_vec();
            issue(ins);
        end

        last_vd = 5'd31;
        prev_vd = 5'd30;
        for (int n = 0; n < N_RANDOM; n++) begin
            ins = random_instr(last_vd, prev_vd);
            issue(ins);
            prev_vd = last_vd;
            last_vd = ins.vd;
        end

        ins = '0;
        while (results_seen < sent_cnt) begin
            cycle(1'b0, ins, taken);
        end
        repeat (20) cycle(1'b0, ins, taken);    // Any stray result shows up here.

        assert (icredit_cnt == sent_cnt) else begin
            value_errors++;
            $display("FAILED at %0t: instr_credit pulses = %0d, expected %0d",
                     $time, icredit_cnt, sent_cnt);
        end
        assert (results_seen == sent_cnt) else begin
            value_errors++;
            $display("FAILED at %0t: result_valid pulses = %0d, expected %0d",
                     $time, results_seen, sent_cnt);
        end

        $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vec_unit_top.sv
`include "vec_cfg.svh"

module vec_unit_top
    import vec_pkg::*;
(
    input  logic        CLK,
    input  logic        reset,
    input  logic        instr_valid,
    input  vec_instr_t  instr,
    output logic        instr_credit,
    output logic        result_valid,
    output vec_result_t result,
    input  logic        result_credit
);

    logic        iq_valid;
    vec_instr_t  iq_instr;
    logic        rq_credit;    // One pulse per result queue pop.
    logic        wb_valid;
    vec_result_t wb;

    // Its credits are result queue slots, so the pipeline never has to stall.
    vec_credit_fifo #(
        .item_t       (vec_instr_t),
        .DEPTH        (`VEC_IQ_DEPTH),
        .INIT_CREDITS (`VEC_RQ_DEPTH)
    ) u_issue_q (
        .CLK        (CLK),
        .reset      (reset),
        .in_valid   (instr_valid),
        .in_data    (instr),
        .in_credit  (instr_credit),
        .out_valid  (iq_valid),
        .out_data   (iq_instr),
        .out_credit (rq_credit)
    );

    vec_exec_pipe u_exec_pipe (
        .CLK         (CLK),
        .reset       (reset),
        .instr_valid (iq_valid),
        .instr       (iq_instr),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    vec_credit_fifo #(
        .item_t       (vec_result_t),
        .DEPTH        (`VEC_RQ_DEPTH),
        .INIT_CREDITS (`VEC_OUT_CREDITS)
    ) u_result_q (
        .CLK        (CLK),
        .reset      (reset),
        .in_valid   (wb_valid),
        .in_data    (wb),
        .in_credit  (rq_credit),
        .out_valid  (result_valid),
        .out_data   (result),
        .out_credit (result_credit)
    );

endmodule

// File: vec_exec_pipe.sv
module vec_exec_pipe
    import vec_pkg::*;
(
    input  logic        CLK,
    input  logic        reset,
    input  logic        instr_valid,
    input  vec_instr_t  instr,
    output logic        wb_valid,
    output vec_result_t wb
);

    vec_uop_t    dec_uop;
    vec_data_t   rf_a;
    vec_data_t   rf_b;

    logic        opr_valid;
    vec_uop_t    opr_uop;
    vec_data_t   opr_a;
    vec_data_t   opr_b;

    vec_data_t   alu_a;
    vec_data_t   alu_b;
    logic        alu_valid;
    vec_result_t alu_res;
    logic        alu_we;

    vec_decode u_decode (
        .instr (instr),
        .uop   (dec_uop)
    );

    vec_regfile u_regfile (
        .CLK       (CLK),
        .reset     (reset),
        .rd_idx_a  (dec_uop.vs1),
        .rd_idx_b  (dec_uop.vs2),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (alu_we),
        .wr_idx    (alu_res.vd),
        .wr_data   (alu_res.data)
    );

    always_ff @(posedge CLK) begin
        if (reset) begin
            opr_valid <= 1'b0;
        end else begin
            opr_valid <= instr_valid;
        end
    end

    always_ff @(posedge CLK) begin
        opr_uop <= dec_uop;
        opr_a   <= rf_a;
        opr_b   <= rf_b;
    end

    // The previous instruction has not reached the register file yet,
    // so its result is taken straight from the ALU output register.
    assign alu_a = (alu_we && alu_res.vd == opr_uop.vs1) ? alu_res.data : opr_a;
    assign alu_b = (alu_we && alu_res.vd == opr_uop.vs2) ? alu_res.data : opr_b;

    vec_alu u_alu (
        .CLK       (CLK),
        .reset     (reset),
        .op_valid  (opr_valid),
        .op        (opr_uop),
        .opnd_a    (alu_a),
        .opnd_b    (alu_b),
        .res_valid (alu_valid),
        .res       (alu_res),
        .res_we    (alu_we)
    );

    assign wb_valid = alu_valid;
    assign wb       = alu_res;

endmodule

// File: vec_alu.sv
`include "vec_cfg.svh"

module vec_alu
    import vec_pkg::*;
(
    input  logic        CLK,
    input  logic        reset,
    input  logic        op_valid,
    input  vec_uop_t    op,
    input  vec_data_t   opnd_a,
    input  vec_data_t   opnd_b,
    output logic        res_valid,
    output vec_result_t res,
    output logic        res_we
);

    localparam int SH_W = $clog2(`VEC_ELEM_W);

    vec_data_t lane_res;

    always_comb begin
        for (int i = 0; i < `VEC_LANES; i++) begin
            case (op.func)
                VF_ADD:  lane_res[i] = opnd_a[i] + opnd_b[i];
                VF_SUB:  lane_res[i] = opnd_a[i] - opnd_b[i];
                VF_SHR:  lane_res[i] = opnd_a[i] >> opnd_b[i][SH_W-1:0];
                VF_SHL:  lane_res[i] = opnd_a[i] << opnd_b[i][SH_W-1:0];
                VF_AND:  lane_res[i] = opnd_a[i] & opnd_b[i];
                VF_OR:   lane_res[i] = opnd_a[i] | opnd_b[i];
                VF_XOR:  lane_res[i] = opnd_a[i] ^ opnd_b[i];
                VF_MUL:  lane_res[i] = opnd_a[i] * opnd_b[i];    // Low half only.
                VF_LOAD: lane_res[i] = op.data[i];
                default: lane_res[i] = '0;
            endcase

            if (op.illegal) begin
                lane_res[i] = '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_we    <= 1'b0;
        end else begin
            res_valid <= op_valid;
            res_we    <= op_valid && op.we;
        end
    end

    always_ff @(posedge CLK) begin
        res.vd      <= op.vd;
        res.illegal <= op.illegal;
        res.data    <= lane_res;
    end

    // Decode must never mark an illegal encoding as writing a register.
    a_no_illegal_write: assert property (
        @(posedge CLK) disable iff (reset)
        res_we |-> !res.illegal
    );

endmodule

// File: vec_regfile.sv
`include "vec_cfg.svh"

module vec_regfile
    import vec_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  vreg_idx_t rd_idx_a,
    input  vreg_idx_t rd_idx_b,
    output vec_data_t rd_data_a,
    output vec_data_t rd_data_b,
    input  logic      wr_en,
    input  vreg_idx_t wr_idx,
    input  vec_data_t wr_data
);

    vec_data_t regs [`VEC_REGS];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `VEC_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // A read of the register being written sees the new value.
    always_comb begin
        if (wr_en && wr_idx == rd_idx_a) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_idx_a];
        end

        if (wr_en && wr_idx == rd_idx_b) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_idx_b];
        end
    end

endmodule

// File: vec_decode.sv
module vec_decode
    import vec_pkg::*;
(
    input  vec_instr_t instr,
    output vec_uop_t   uop
);

    always_comb begin
        uop.vd   = instr.vd;
        uop.vs1  = instr.vs1;
        uop.vs2  = instr.vs2;
        uop.data = instr.data;

        // Anything not matched below is treated as illegal.
        uop.func    = VF_ADD;
        uop.we      = 1'b0;
        uop.illegal = 1'b1;

        case (instr.opcode)
            OP_VARITH: begin
                if (instr.funct3 == OPIVV && instr.funct7[6:3] == 4'd0) begin
                    uop.func    = vec_func_t'({1'b0, instr.funct7[2:0]});
                    uop.we      = 1'b1;
                    uop.illegal = 1'b0;
                end
            end
            OP_VLOAD: begin
                uop.func    = VF_LOAD;    // The funct fields are ignored here.
                uop.we      = 1'b1;
                uop.illegal = 1'b0;
            end
            default: begin
                uop.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: vec_credit_fifo.sv
module vec_credit_fifo #(
    parameter type item_t = logic,
    parameter int DEPTH = 4,
    parameter int INIT_CREDITS = 4
) (
    input  logic  CLK,
    input  logic  reset,
    input  logic  in_valid,
    input  item_t in_data,
    output logic  in_credit,
    output logic  out_valid,
    output item_t out_data,
    input  logic  out_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CR_W = $clog2(INIT_CREDITS + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CR_W-1:0]  credits;    // Credits still held toward the receiver.
    logic             pop;

    assign pop = (count != '0) && (credits != '0);

    assign out_valid = pop;
    assign out_data  = mem[rd_ptr];
    assign in_credit = pop;    // A freed slot goes straight back to the sender.

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CR_W'(INIT_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(in_valid) - CNT_W'(pop);
            credits <= credits + CR_W'(out_credit) - CR_W'(pop);
        end
    end

    // The sender only pushes on a credit, so a full buffer never sees a push.
    a_no_push_full: assert property (
        @(posedge CLK) disable iff (reset)
        in_valid |-> count != CNT_W'(DEPTH)
    );

    // The receiver can never return more credits than it handed out.
    a_credit_bound: assert property (
        @(posedge CLK) disable iff (reset)
        credits <= CR_W'(INIT_CREDITS)
    );

endmodule

// File: vec_pkg.sv
`include "vec_cfg.svh"

package vec_pkg;

    typedef logic [`VEC_LANES-1:0][`VEC_ELEM_W-1:0] vec_data_t;

    typedef logic [4:0] vreg_idx_t;

    // Lane functions. The arithmetic codes equal funct7 of the OPIVV encoding.
    typedef enum logic [3:0] {
        VF_ADD  = 4'd0,
        VF_SUB  = 4'd1,
        VF_SHR  = 4'd2,
        VF_SHL  = 4'd3,
        VF_AND  = 4'd4,
        VF_OR   = 4'd5,
        VF_XOR  = 4'd6,
        VF_MUL  = 4'd7,
        VF_LOAD = 4'd8
    } vec_func_t;

    localparam logic [6:0] OP_VARITH = 7'b1010111;
    localparam logic [6:0] OP_VLOAD  = 7'b0000111;
    localparam logic [2:0] OPIVV     = 3'b000;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        vreg_idx_t  vd;
        vreg_idx_t  vs1;
        vreg_idx_t  vs2;
        vec_data_t  data;    // Only meaningful for loads.
    } vec_instr_t;

    typedef struct packed {
        vec_func_t func;
        vreg_idx_t vd;
        vreg_idx_t vs1;
        vreg_idx_t vs2;
        logic      we;
        logic      illegal;
        vec_data_t data;
    } vec_uop_t;

    typedef struct packed {
        vreg_idx_t vd;
        logic      illegal;
        vec_data_t data;
    } vec_result_t;

endpackage

// File: vec_cfg.svh
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Shape of one vector register.
`define VEC_LANES 32
`define VEC_ELEM_W 32

// Architectural vector registers.
`define VEC_REGS 32

// The issuer starts with one credit per issue queue entry.
`define VEC_IQ_DEPTH 4

// Each instruction leaving the issue queue reserves one of these slots.
`define VEC_RQ_DEPTH 4

// Credits the consumer grants to the result queue after reset.
`define VEC_OUT_CREDITS 2

`endif
